//--- design/pyramid_defs.svh
`ifndef PYRAMID_DEFS_SVH
`define PYRAMID_DEFS_SVH

// pixel depth of every level
`define PIX_BITS 8

// octave 1 image size, octave 2 is half of it in each direction
`define IMG_W 8
`define IMG_H 8

// one address space covers a whole 8x8 image
`define ADDR_BITS 6

// read enable to data, both for the buffers and the source memory
`define RD_LATENCY 2

// binomial 3x3 kernel sums to 16
`define BLUR_SHIFT 4

`endif

//--- design/pyramid_pkg.sv
`default_nettype none

`include "pyramid_defs.svh"

package pyramid_pkg;

    typedef logic [`PIX_BITS-1:0] pixel_t;
    typedef logic [`ADDR_BITS-1:0] addr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t pixel;
    } mem_wr_t;

    typedef enum logic [1:0] {O1L1, O1L2, O2L1, O2L2} level_e;

    // one tagged write on the shared level port
    typedef struct packed {
        logic   valid;
        level_e level;
        addr_t  addr;
        pixel_t pixel;
    } level_wr_t;

    typedef enum logic {OCT1, OCT2} octave_e;   // 8x8 or 4x4

    typedef enum logic [2:0] {IDLE, LOAD, BLUR1, DECIM, BLUR2} pyr_state_e;

endpackage

`default_nettype wire

//--- design/pixel_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pyramid_defs.svh"

// stands in for a block ram with output register, two cycle read
module pixel_buffer (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  pyramid_pkg::mem_wr_t wr,
    input  pyramid_pkg::mem_rd_t rd,
    output pyramid_pkg::pixel_t  rd_pixel
);

    pyramid_pkg::pixel_t mem [2**`ADDR_BITS];
    pyramid_pkg::pixel_t rd_data_q;   // array read stage
    logic                rd_en_q;

    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.pixel;
        end
        if (rd.en) begin
            rd_data_q <= mem[rd.addr];
        end
        if (rd_en_q) begin
            rd_pixel <= rd_data_q;   // output register
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= rd.en;
        end
    end

endmodule

`default_nettype wire

//--- design/source_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pyramid_defs.svh"

module source_reader (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  wire                  start,
    output pyramid_pkg::mem_rd_t src_rd,
    input  pyramid_pkg::pixel_t  src_pixel,
    output pyramid_pkg::mem_wr_t wr,
    output logic                 done
);

    localparam pyramid_pkg::addr_t LAST_ADDR = pyramid_pkg::addr_t'(`IMG_W * `IMG_H - 1);

    logic                 active;
    pyramid_pkg::addr_t   addr;
    pyramid_pkg::mem_rd_t rd_pipe [`RD_LATENCY];   // matches the memory latency

    assign src_rd.en   = active;
    assign src_rd.addr = addr;

    // returning pixel lines up with the oldest pipe entry
    assign wr.en    = rd_pipe[`RD_LATENCY-1].en;
    assign wr.addr  = rd_pipe[`RD_LATENCY-1].addr;
    assign wr.pixel = src_pixel;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            active <= 1'b0;
            addr   <= '0;
            done   <= 1'b0;
            for (int i = 0; i < `RD_LATENCY; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            if (start) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (active) begin
                addr <= addr + 1'b1;
                if (addr == LAST_ADDR) begin
                    active <= 1'b0;
                end
            end
            rd_pipe[0] <= src_rd;
            for (int i = 1; i < `RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
            done <= wr.en && (wr.addr == LAST_ADDR);   // after the final write
        end
    end

endmodule

`default_nettype wire

//--- design/blur_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "pyramid_defs.svh"

// 3x3 binomial blur, nine tap reads per output pixel, edges clamped
module blur_engine (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  wire                  start,
    input  pyramid_pkg::octave_e octave,
    output pyramid_pkg::mem_rd_t rd,
    input  pyramid_pkg::pixel_t  rd_pixel,
    output pyramid_pkg::mem_wr_t wr,
    output logic                 done
);

    localparam int ACC_BITS = `PIX_BITS + `BLUR_SHIFT;

    typedef struct packed {
        logic               en;
        logic               last;     // ninth tap of a pixel
        logic [1:0]         wshift;   // weight 1, 2 or 4 as a shift
        pyramid_pkg::addr_t out_addr;
    } tap_t;

    logic [3:0]         side_w;
    logic [3:0]         side_h;
    pyramid_pkg::addr_t last_addr;

    logic          active;
    logic [2:0]    x;
    logic [2:0]    y;
    logic [1:0]    tap_col;
    logic [1:0]    tap_row;
    int            nx;
    int            ny;
    tap_t          tap;
    tap_t          tap_pipe [`RD_LATENCY];
    logic [ACC_BITS-1:0] acc;
    logic [ACC_BITS-1:0] acc_next;

    assign side_w    = (octave == pyramid_pkg::OCT1) ? 4'(`IMG_W) : 4'(`IMG_W / 2);
    assign side_h    = (octave == pyramid_pkg::OCT1) ? 4'(`IMG_H) : 4'(`IMG_H / 2);
    assign last_addr = pyramid_pkg::addr_t'(side_w * side_h - 1);

    // neighbour coordinates, clamped to the current image
    always_comb begin
        nx = int'(x) + int'(tap_col) - 1;
        ny = int'(y) + int'(tap_row) - 1;
        if (nx < 0) begin
            nx = 0;
        end else if (nx > int'(side_w) - 1) begin
            nx = int'(side_w) - 1;
        end
        if (ny < 0) begin
            ny = 0;
        end else if (ny > int'(side_h) - 1) begin
            ny = int'(side_h) - 1;
        end
    end

    assign rd.en   = active;
    assign rd.addr = pyramid_pkg::addr_t'(ny * int'(side_w) + nx);

    assign tap.en       = active;
    assign tap.last     = (tap_col == 2'd2) && (tap_row == 2'd2);
    assign tap.wshift   = 2'(tap_col == 2'd1) + 2'(tap_row == 2'd1);
    assign tap.out_addr = pyramid_pkg::addr_t'(int'(y) * int'(side_w) + int'(x));

    assign acc_next = acc + (ACC_BITS'(rd_pixel) << tap_pipe[`RD_LATENCY-1].wshift);

    // tap sweep, column fastest, then row, then x, then y
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            active  <= 1'b0;
            x       <= '0;
            y       <= '0;
            tap_col <= '0;
            tap_row <= '0;
        end else if (start) begin
            active  <= 1'b1;
            x       <= '0;
            y       <= '0;
            tap_col <= '0;
            tap_row <= '0;
        end else if (active) begin
            if (tap_col != 2'd2) begin
                tap_col <= tap_col + 1'b1;
            end else begin
                tap_col <= '0;
                if (tap_row != 2'd2) begin
                    tap_row <= tap_row + 1'b1;
                end else begin
                    tap_row <= '0;
                    if (x != 3'(side_w - 1)) begin
                        x <= x + 1'b1;
                    end else begin
                        x <= '0;
                        if (y != 3'(side_h - 1)) begin
                            y <= y + 1'b1;
                        end else begin
                            active <= 1'b0;   // final tap issued
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            acc  <= '0;
            wr   <= '0;
            done <= 1'b0;
            for (int i = 0; i < `RD_LATENCY; i++) begin
                tap_pipe[i] <= '0;
            end
        end else begin
            tap_pipe[0] <= tap;
            for (int i = 1; i < `RD_LATENCY; i++) begin
                tap_pipe[i] <= tap_pipe[i-1];
            end
            wr.en <= 1'b0;
            if (start) begin
                acc <= '0;
            end else if (tap_pipe[`RD_LATENCY-1].en) begin
                if (tap_pipe[`RD_LATENCY-1].last) begin
                    acc      <= '0;
                    wr.en    <= 1'b1;
                    wr.addr  <= tap_pipe[`RD_LATENCY-1].out_addr;
                    wr.pixel <= pyramid_pkg::pixel_t'(acc_next >> `BLUR_SHIFT);   // truncates
                end else begin
                    acc <= acc_next;
                end
            end
            done <= wr.en && (wr.addr == last_addr);
        end
    end

endmodule

`default_nettype wire

//--- design/decimator.sv
`timescale 1ns/1ps
`default_nettype none

`include "pyramid_defs.svh"

// keeps every second pixel of every second row, 8x8 in, 4x4 out
module decimator (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  wire                  start,
    output pyramid_pkg::mem_rd_t rd,
    input  pyramid_pkg::pixel_t  rd_pixel,
    output pyramid_pkg::mem_wr_t wr,
    output logic                 done
);

    localparam int OUT_W = `IMG_W / 2;
    localparam int OUT_H = `IMG_H / 2;
    localparam pyramid_pkg::addr_t LAST_OUT = pyramid_pkg::addr_t'(OUT_W * OUT_H - 1);

    logic                 active;
    logic [1:0]           ox;
    logic [1:0]           oy;
    pyramid_pkg::mem_rd_t out_pipe [`RD_LATENCY];   // output address rides along

    assign rd.en   = active;
    assign rd.addr = pyramid_pkg::addr_t'(2 * oy * `IMG_W + 2 * ox);

    assign wr.en    = out_pipe[`RD_LATENCY-1].en;
    assign wr.addr  = out_pipe[`RD_LATENCY-1].addr;
    assign wr.pixel = rd_pixel;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            active <= 1'b0;
            ox     <= '0;
            oy     <= '0;
            done   <= 1'b0;
            for (int i = 0; i < `RD_LATENCY; i++) begin
                out_pipe[i] <= '0;
            end
        end else begin
            if (start) begin
                active <= 1'b1;
                ox     <= '0;
                oy     <= '0;
            end else if (active) begin
                if (ox != 2'(OUT_W - 1)) begin
                    ox <= ox + 1'b1;
                end else begin
                    ox <= '0;
                    oy <= oy + 1'b1;
                    if (oy == 2'(OUT_H - 1)) begin
                        active <= 1'b0;
                    end
                end
            end
            out_pipe[0].en   <= active;
            out_pipe[0].addr <= pyramid_pkg::addr_t'(oy * OUT_W + ox);
            for (int i = 1; i < `RD_LATENCY; i++) begin
                out_pipe[i] <= out_pipe[i-1];
            end
            done <= wr.en && (wr.addr == LAST_OUT);
        end
    end

endmodule

`default_nettype wire

//--- design/pyramid_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pyramid_sequencer (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    start,
    output logic                   load_start,
    output logic                   blur_start,
    output logic                   decim_start,
    input  wire                    load_done,
    input  wire                    blur_done,
    input  wire                    decim_done,
    output pyramid_pkg::octave_e   blur_octave,
    input  pyramid_pkg::mem_wr_t   load_wr,
    input  pyramid_pkg::mem_wr_t   blur_wr,
    input  pyramid_pkg::mem_wr_t   decim_wr,
    input  pyramid_pkg::mem_rd_t   blur_rd,
    input  pyramid_pkg::mem_rd_t   decim_rd,
    output pyramid_pkg::mem_wr_t   buf_a_wr,
    output pyramid_pkg::mem_wr_t   buf_b_wr,
    output pyramid_pkg::mem_rd_t   buf_a_rd,
    output pyramid_pkg::mem_rd_t   buf_b_rd,
    input  pyramid_pkg::pixel_t    buf_a_pixel,
    input  pyramid_pkg::pixel_t    buf_b_pixel,
    output pyramid_pkg::pixel_t    blur_pixel,
    output pyramid_pkg::pixel_t    decim_pixel,
    output pyramid_pkg::level_wr_t level_wr,
    output logic                   done
);

    pyramid_pkg::pyr_state_e state;
    logic                    entered;   // first cycle of a new stage
    pyramid_pkg::mem_wr_t    stage_wr;
    pyramid_pkg::level_e     stage_level;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= pyramid_pkg::IDLE;
            entered     <= 1'b0;
            load_start  <= 1'b0;
            blur_start  <= 1'b0;
            decim_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            entered     <= 1'b0;
            load_start  <= entered && (state == pyramid_pkg::LOAD);
            blur_start  <= entered && (state == pyramid_pkg::BLUR1 || state == pyramid_pkg::BLUR2);
            decim_start <= entered && (state == pyramid_pkg::DECIM);
            done        <= (state == pyramid_pkg::BLUR2) && blur_done;
            case (state)
                pyramid_pkg::IDLE: if (start) begin
                    state   <= pyramid_pkg::LOAD;
                    entered <= 1'b1;
                end
                pyramid_pkg::LOAD: if (load_done) begin
                    state   <= pyramid_pkg::BLUR1;
                    entered <= 1'b1;
                end
                pyramid_pkg::BLUR1: if (blur_done) begin
                    state   <= pyramid_pkg::DECIM;
                    entered <= 1'b1;
                end
                pyramid_pkg::DECIM: if (decim_done) begin
                    state   <= pyramid_pkg::BLUR2;
                    entered <= 1'b1;
                end
                pyramid_pkg::BLUR2: if (blur_done) begin
                    state <= pyramid_pkg::IDLE;
                end
                default: state <= pyramid_pkg::IDLE;
            endcase
        end
    end

    assign blur_octave = (state == pyramid_pkg::BLUR2) ? pyramid_pkg::OCT2 : pyramid_pkg::OCT1;

    // buffer A and B swap roles each stage, idle ports stay disabled
    always_comb begin
        buf_a_wr    = '0;
        buf_b_wr    = '0;
        buf_a_rd    = '0;
        buf_b_rd    = '0;
        blur_pixel  = '0;
        decim_pixel = '0;
        stage_wr    = '0;
        stage_level = pyramid_pkg::O1L1;
        case (state)
            pyramid_pkg::LOAD: begin
                buf_a_wr = load_wr;
                stage_wr = load_wr;
            end
            pyramid_pkg::BLUR1, pyramid_pkg::BLUR2: begin
                buf_a_rd    = blur_rd;
                blur_pixel  = buf_a_pixel;
                buf_b_wr    = blur_wr;
                stage_wr    = blur_wr;
                stage_level = (state == pyramid_pkg::BLUR1) ? pyramid_pkg::O1L2 : pyramid_pkg::O2L2;
            end
            pyramid_pkg::DECIM: begin
                buf_b_rd    = decim_rd;
                decim_pixel = buf_b_pixel;
                buf_a_wr    = decim_wr;   // octave 2 lives in the low addresses
                stage_wr    = decim_wr;
                stage_level = pyramid_pkg::O2L1;
            end
            default: ;
        endcase
    end

    assign level_wr.valid = stage_wr.en;
    assign level_wr.level = stage_level;
    assign level_wr.addr  = stage_wr.addr;
    assign level_wr.pixel = stage_wr.pixel;

endmodule

`default_nettype wire

//--- design/pyramid_top.sv
`timescale 1ns/1ps
`default_nettype none

module pyramid_top (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    start,
    output pyramid_pkg::mem_rd_t   src_rd,
    input  pyramid_pkg::pixel_t    src_pixel,
    output pyramid_pkg::level_wr_t level_wr,
    output logic                   done
);

    logic                 load_start, blur_start, decim_start;
    logic                 load_done, blur_done, decim_done;
    pyramid_pkg::octave_e blur_octave;
    pyramid_pkg::mem_wr_t load_wr, blur_wr, decim_wr;
    pyramid_pkg::mem_rd_t blur_rd, decim_rd;
    pyramid_pkg::mem_wr_t buf_a_wr, buf_b_wr;
    pyramid_pkg::mem_rd_t buf_a_rd, buf_b_rd;
    pyramid_pkg::pixel_t  buf_a_pixel, buf_b_pixel;
    pyramid_pkg::pixel_t  blur_pixel, decim_pixel;

    source_reader u_source_reader (
        .clk_in(clk_in), .rst_in(rst_in), .start(load_start),
        .src_rd(src_rd), .src_pixel(src_pixel),
        .wr(load_wr), .done(load_done)
    );

    blur_engine u_blur_engine (
        .clk_in(clk_in), .rst_in(rst_in), .start(blur_start), .octave(blur_octave),
        .rd(blur_rd), .rd_pixel(blur_pixel),
        .wr(blur_wr), .done(blur_done)
    );

    decimator u_decimator (
        .clk_in(clk_in), .rst_in(rst_in), .start(decim_start),
        .rd(decim_rd), .rd_pixel(decim_pixel),
        .wr(decim_wr), .done(decim_done)
    );

    pyramid_sequencer u_sequencer (
        .clk_in(clk_in), .rst_in(rst_in), .start(start),
        .load_start(load_start), .blur_start(blur_start), .decim_start(decim_start),
        .load_done(load_done), .blur_done(blur_done), .decim_done(decim_done),
        .blur_octave(blur_octave),
        .load_wr(load_wr), .blur_wr(blur_wr), .decim_wr(decim_wr),
        .blur_rd(blur_rd), .decim_rd(decim_rd),
        .buf_a_wr(buf_a_wr), .buf_b_wr(buf_b_wr),
        .buf_a_rd(buf_a_rd), .buf_b_rd(buf_b_rd),
        .buf_a_pixel(buf_a_pixel), .buf_b_pixel(buf_b_pixel),
        .blur_pixel(blur_pixel), .decim_pixel(decim_pixel),
        .level_wr(level_wr), .done(done)
    );

    pixel_buffer u_buf_a (
        .clk_in(clk_in), .rst_in(rst_in), .wr(buf_a_wr), .rd(buf_a_rd), .rd_pixel(buf_a_pixel)
    );

    pixel_buffer u_buf_b (
        .clk_in(clk_in), .rst_in(rst_in), .wr(buf_b_wr), .rd(buf_b_rd), .rd_pixel(buf_b_pixel)
    );

endmodule

`default_nettype wire

//--- testbench/pyramid_sva.sv
`timescale 1ns/1ps
`default_nettype none

module pyramid_sva (
    input wire                     clk_in,
    input wire                     rst_in,
    input pyramid_pkg::pyr_state_e state,
    input wire                     done,
    input pyramid_pkg::level_wr_t  level_wr,
    input pyramid_pkg::mem_rd_t    buf_a_rd,
    input pyramid_pkg::mem_rd_t    buf_b_rd
);

    int fail_count = 0;   // assertion failures so far

    done_single: assert property (@(posedge clk_in) disable iff (rst_in) done |=> !done)
        else begin
            $error("done high on two consecutive cycles");
            fail_count++;
        end

    // level writes only while a stage runs
    write_not_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        level_wr.valid |-> state != pyramid_pkg::IDLE)
        else begin
            $error("level write while idle");
            fail_count++;
        end

    idle_no_reads: assert property (@(posedge clk_in) disable iff (rst_in)
        state == pyramid_pkg::IDLE |-> !buf_a_rd.en && !buf_b_rd.en)
        else begin
            $error("buffer read enabled while idle");
            fail_count++;
        end

endmodule

bind pyramid_sequencer pyramid_sva u_sva (
    .clk_in(clk_in), .rst_in(rst_in), .state(state), .done(done),
    .level_wr(level_wr), .buf_a_rd(buf_a_rd), .buf_b_rd(buf_b_rd)
);

`default_nettype wire

//--- testbench/pyramid_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pyramid_defs.svh"

module pyramid_tb;

    localparam int NUM_TESTS       = 4;
    localparam int CYCLE_LIMIT     = NUM_TESTS * 1000;   // each run is well under 1000 cycles
    localparam int MID_START_DELAY = 200;                // lands inside BLUR1
    localparam int SETTLE          = 40;

    typedef enum logic [1:0] {PAT_RAMP, PAT_CONST, PAT_CHECKER, PAT_RANDOM} pattern_e;

    typedef struct packed {
        pattern_e   pattern;
        logic       mid_start;    // second start pulse during the run
        logic [7:0] exp_writes;   // 64 + 64 + 16 + 16
        logic [1:0] exp_done;
    } test_row_t;

    logic                   clk_in;
    logic                   rst_in;
    logic                   start;
    pyramid_pkg::mem_rd_t   src_rd;
    pyramid_pkg::pixel_t    src_pixel;
    pyramid_pkg::level_wr_t level_wr;
    logic                   done;

    test_row_t           tests [NUM_TESTS];
    pyramid_pkg::pixel_t src_mem [64];
    pyramid_pkg::pixel_t src_q1;
    pyramid_pkg::pixel_t exp_pix [4][64];
    pyramid_pkg::pixel_t got_pix [4][64];
    int                  got_cnt [4][64];
    integer              seed;
    int                  cycles;
    int                  errors;
    int                  passed;
    int                  done_cnt;
    int                  o2l2_writes;
    int                  order_errs;
    int                  idle_errs;
    int                  last_level;
    int                  lvl_idx;
    logic                done_in_place;
    logic                armed;   // a run is expected

    pyramid_top u_dut (
        .clk_in(clk_in), .rst_in(rst_in), .start(start),
        .src_rd(src_rd), .src_pixel(src_pixel),
        .level_wr(level_wr), .done(done)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // source memory, data two cycles after the enable
    always @(posedge clk_in) begin
        if (src_rd.en === 1'b1) begin
            src_q1 <= src_mem[src_rd.addr];
        end
        src_pixel <= #2 src_q1;
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, done never arrived", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // capture of the level port, sampled mid cycle
    always @(negedge clk_in) begin
        if (!rst_in && armed) begin
            if (level_wr.valid === 1'b1) begin
                lvl_idx = int'(level_wr.level);
                got_pix[lvl_idx][level_wr.addr] = level_wr.pixel;
                got_cnt[lvl_idx][level_wr.addr]++;
                if (lvl_idx < last_level || done_cnt > 0) begin
                    order_errs++;
                end
                if (lvl_idx == 3) begin
                    o2l2_writes++;
                end
                last_level = lvl_idx;
            end
            if (done === 1'b1) begin
                done_cnt++;
                done_in_place = (o2l2_writes == 16);
            end
        end else if (!rst_in && (level_wr.valid !== 1'b0 || done !== 1'b0)) begin
            idle_errs++;
        end
    end

    function automatic int clamp_coord(int c, int side);
        if (c < 0) begin
            return 0;
        end
        return (c > side - 1) ? side - 1 : c;
    endfunction

    // 1-2-1 by 1-2-1 kernel over one stored level
    function automatic pyramid_pkg::pixel_t blur_at(int lvl, int side, int x, int y);
        int sum;
        int w;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                w = ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
                sum += w * exp_pix[lvl][clamp_coord(y + dy, side) * side
                                        + clamp_coord(x + dx, side)];
            end
        end
        return pyramid_pkg::pixel_t'(sum >> `BLUR_SHIFT);
    endfunction

    task automatic fill_source(input pattern_e pat);
        for (int a = 0; a < 64; a++) begin
            case (pat)
                PAT_RAMP:    src_mem[a] = pyramid_pkg::pixel_t'(a * 4 + 1);
                PAT_CONST:   src_mem[a] = 8'hff;
                PAT_CHECKER: src_mem[a] = (((a % 8) ^ (a / 8)) & 1) ? 8'hff : 8'h00;
                default:     src_mem[a] = pyramid_pkg::pixel_t'($random(seed));
            endcase
        end
    endtask

    task automatic build_reference();
        for (int a = 0; a < 64; a++) begin
            exp_pix[0][a] = src_mem[a];
        end
        for (int a = 0; a < 64; a++) begin
            exp_pix[1][a] = blur_at(0, `IMG_W, a % `IMG_W, a / `IMG_W);
        end
        for (int a = 0; a < 16; a++) begin
            exp_pix[2][a] = exp_pix[1][2 * (a / 4) * `IMG_W + 2 * (a % 4)];
        end
        for (int a = 0; a < 16; a++) begin
            exp_pix[3][a] = blur_at(2, 4, a % 4, a / 4);
        end
    endtask

    task automatic clear_capture();
        for (int l = 0; l < 4; l++) begin
            for (int a = 0; a < 64; a++) begin
                got_cnt[l][a] = 0;
                got_pix[l][a] = '0;
            end
        end
        done_cnt      = 0;
        o2l2_writes   = 0;
        order_errs    = 0;
        last_level    = 0;
        done_in_place = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk_in);
        #2 start = 1'b1;
        @(posedge clk_in);
        #2 start = 1'b0;
    endtask

    task automatic check_pixel(input pyramid_pkg::level_e lvl, input pyramid_pkg::addr_t addr,
                               input int count, input pyramid_pkg::pixel_t got,
                               input pyramid_pkg::pixel_t exp);
        if (count != 1) begin
            $display("%s address %0d was written %0d times", lvl.name(), addr, count);
            errors++;
        end else if (got !== exp) begin
            $display("Fail at %0t: %s address %0d got %0h expected %0h",
                     $time, lvl.name(), addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_done(input int pulses, input int exp_pulses, input logic in_place);
        if (pulses != exp_pulses) begin
            $display("done pulsed %0d times, expected %0d", pulses, exp_pulses);
            errors++;
        end else if (!in_place) begin
            $display("done pulsed before the last O2L2 write");
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t row;
        pattern_e  pat;
        int        errs_before;
        int        total;
        row         = tests[t];
        pat         = row.pattern;
        errs_before = errors;
        fill_source(pat);
        build_reference();
        clear_capture();
        armed = 1'b1;
        pulse_start();
        if (row.mid_start) begin
            repeat (MID_START_DELAY) @(posedge clk_in);
            pulse_start();   // must be ignored
        end
        while (done_cnt == 0) begin
            @(posedge clk_in);
        end
        repeat (SETTLE) @(posedge clk_in);   // a second run would show up here
        armed = 1'b0;
        total = 0;
        for (int l = 0; l < 4; l++) begin
            for (int a = 0; a < 64; a++) begin
                total += got_cnt[l][a];
                if (a < ((l < 2) ? 64 : 16)) begin
                    check_pixel(pyramid_pkg::level_e'(l), pyramid_pkg::addr_t'(a),
                                got_cnt[l][a], got_pix[l][a], exp_pix[l][a]);
                end else if (got_cnt[l][a] != 0) begin
                    $display("stray write to level %0d address %0d", l, a);
                    errors++;
                end
            end
        end
        if (total != int'(row.exp_writes)) begin
            $display("saw %0d level writes instead of %0d", total, row.exp_writes);
            errors++;
        end
        if (order_errs != 0) begin
            $display("%0d writes arrived out of level order or after done", order_errs);
            errors++;
        end
        if (idle_errs != 0) begin
            $display("level_wr valid or done went high while no run was started");
            errors++;
            idle_errs = 0;
        end
        check_done(done_cnt, int'(row.exp_done), done_in_place);
        if (errors == errs_before) begin
            passed++;
            $display("test %0d (%s, mid start %0b) ok", t, pat.name(), row.mid_start);
        end else begin
            $display("test %0d (%s, mid start %0b) had %0d errors",
                     t, pat.name(), row.mid_start, errors - errs_before);
        end
    endtask

    initial begin
        seed      = 24;
        cycles    = 0;
        errors    = 0;
        passed    = 0;
        idle_errs = 0;
        armed     = 1'b0;
        start     = 1'b0;
        src_pixel = '0;
        src_q1    = '0;
        rst_in    = 1'b1;
        tests[0]  = '{PAT_RAMP,    1'b0, 8'd160, 2'd1};
        tests[1]  = '{PAT_CONST,   1'b0, 8'd160, 2'd1};
        tests[2]  = '{PAT_CHECKER, 1'b1, 8'd160, 2'd1};
        tests[3]  = '{PAT_RANDOM,  1'b1, 8'd160, 2'd1};
        repeat (8) @(posedge clk_in);
        #2 rst_in = 1'b0;
        repeat (4) @(posedge clk_in);   // outputs must stay quiet before start
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        if (u_dut.u_sequencer.u_sva.fail_count != 0) begin
            $display("%0d sequencer assertions failed", u_dut.u_sequencer.u_sva.fail_count);
            errors += u_dut.u_sequencer.u_sva.fail_count;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, passed, NUM_TESTS - passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/pyramid_pkg.sv
design/pixel_buffer.sv
design/source_reader.sv
design/blur_engine.sv
design/decimator.sv
design/pyramid_sequencer.sv
design/pyramid_top.sv
testbench/pyramid_sva.sv
testbench/pyramid_tb.sv

//--- Bender.yml
package:
  name: gauss_pyramid

export_include_dirs:
  - design

sources:
  - design/pyramid_pkg.sv
  - design/pixel_buffer.sv
  - design/source_reader.sv
  - design/blur_engine.sv
  - design/decimator.sv
  - design/pyramid_sequencer.sv
  - design/pyramid_top.sv
  - target: test
    files:
      - testbench/pyramid_sva.sv
      - testbench/pyramid_tb.sv
